// ==== logic/audio_stream_pkg.sv ====
package audio_stream_pkg;

	localparam int sample_bits = 16;

	// Two stereo frames, earliest frame in the low half
	typedef struct packed {
		logic [sample_bits-1:0] right1;
		logic [sample_bits-1:0] left1;
		logic [sample_bits-1:0] right0;
		logic [sample_bits-1:0] left0;
	} sample_word_t;

	// One stereo frame
	typedef struct packed {
		logic [sample_bits-1:0] left;
		logic [sample_bits-1:0] right;
	} stereo_t;

endpackage

// ==== logic/ac97_link_pkg.sv ====
package ac97_link_pkg;

	localparam int frame_bits = 256;
	localparam int tag_bits = 16;	// Also the sync high time
	localparam int slot_bits = 20;

	// Data view, 16-bit value left aligned in the slot
	typedef struct packed {
		logic [15:0] value;
		logic [3:0]  zero;
	} slot_data_t;

	// Command address view of slot 1
	typedef struct packed {
		logic        read;	// 1 for a register read
		logic [6:0]  index;
		logic [11:0] zero;
	} slot_cmd_t;

	typedef union packed {
		slot_data_t data;
		slot_cmd_t  cmd;
	} ac97_slot_u;

	typedef struct packed {
		logic       valid;
		ac97_slot_u slot1;
		ac97_slot_u slot2;
	} cmd_slots_t;

	typedef struct packed {
		logic       valid;
		ac97_slot_u slot3;	// Left
		ac97_slot_u slot4;	// Right
	} pcm_slots_t;

	// Codec setup writes, sent once in this order
	localparam int codec_reg_count = 7;

	localparam logic [6:0] codec_reg_index [codec_reg_count] = '{
		7'h02, 7'h0E, 7'h10, 7'h12, 7'h18, 7'h1A, 7'h1C
	};

	localparam logic [15:0] codec_reg_value [codec_reg_count] = '{
		16'h0000, 16'h8808, 16'h8808, 16'h8808, 16'h0808, 16'h0000, 16'h8000
	};

endpackage

// ==== logic/sample_fifo.sv ====
module sample_fifo #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic                         ac97_bitclk,
	input  logic                         audio_rst_b,
	input  logic                         in_valid,
	output logic                         in_ready,
	input  audio_stream_pkg::sample_word_t in_word,
	output logic                         out_valid,
	input  logic                         out_ready,
	output audio_stream_pkg::sample_word_t out_word
);
	import audio_stream_pkg::*;

	localparam int ptr_w = $clog2(FIFO_DEPTH);
	localparam int cnt_w = $clog2(FIFO_DEPTH + 1);

	sample_word_t       mem [FIFO_DEPTH];
	logic [ptr_w-1:0]   wr_ptr;
	logic [ptr_w-1:0]   rd_ptr;
	logic [cnt_w-1:0]   count;
	logic               push;
	logic               pop;

	// Ready from the count only, no path from out_ready
	assign in_ready = (count != cnt_w'(FIFO_DEPTH));
	assign out_valid = (count != '0);
	assign out_word = mem[rd_ptr];

	assign push = in_valid && in_ready;
	assign pop = out_valid && out_ready;

	always_ff @(posedge ac97_bitclk) begin
		if (push)
			mem[wr_ptr] <= in_word;
	end

	always_ff @(posedge ac97_bitclk or negedge audio_rst_b) begin
		if (!audio_rst_b) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)	// Wrap by compare, depth need not be a power of two
				wr_ptr <= (wr_ptr == ptr_w'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == ptr_w'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

endmodule

// ==== logic/frame_splitter.sv ====
module frame_splitter (
	input  logic                         ac97_bitclk,
	input  logic                         audio_rst_b,
	input  logic                         strobe,
	input  logic                         word_valid,
	output logic                         word_ready,
	input  audio_stream_pkg::sample_word_t word,
	output ac97_link_pkg::pcm_slots_t    pcm
);
	import audio_stream_pkg::*;
	import ac97_link_pkg::*;

	sample_word_t held_word;
	logic         held;	// held_word is being played
	logic         second_half;	// Presenting left1/right1
	stereo_t      half;

	// Pull only at a frame boundary once the held word is spent
	assign word_ready = strobe && (!held || second_half);

	always_ff @(posedge ac97_bitclk) begin
		if (word_valid && word_ready)
			held_word <= word;
	end

	always_ff @(posedge ac97_bitclk or negedge audio_rst_b) begin
		if (!audio_rst_b) begin
			held <= 1'b0;
			second_half <= 1'b0;
		end else if (strobe) begin
			if (held && !second_half) begin
				second_half <= 1'b1;
			end else if (word_valid) begin
				held <= 1'b1;
				second_half <= 1'b0;
			end else begin
				// Underrun, next frame goes out without PCM
				held <= 1'b0;
				second_half <= 1'b0;
			end
		end
	end

	always_comb begin
		if (second_half)
			half = '{left: held_word.left1, right: held_word.right1};
		else
			half = '{left: held_word.left0, right: held_word.right0};

		pcm = '0;
		pcm.valid = held;
		if (held) begin
			pcm.slot3.data.value = half.left;
			pcm.slot3.data.zero = '0;
			pcm.slot4.data.value = half.right;
			pcm.slot4.data.zero = '0;
		end
	end

endmodule

// ==== logic/codec_config.sv ====
module codec_config (
	input  logic                      ac97_bitclk,
	input  logic                      audio_rst_b,
	input  logic                      strobe,
	output ac97_link_pkg::cmd_slots_t cmd
);
	import ac97_link_pkg::*;

	logic [2:0] entry;	// Table entry on offer
	logic       cmd_valid;

	// Entry walks 0 to codec_reg_count and then parks there
	always_ff @(posedge ac97_bitclk or negedge audio_rst_b) begin
		if (!audio_rst_b) begin
			entry <= '0;
			cmd_valid <= 1'b0;
		end else if (strobe) begin
			if (cmd_valid) begin
				entry <= entry + 3'd1;
				cmd_valid <= (entry != 3'(codec_reg_count - 1));
			end else if (entry == '0) begin
				cmd_valid <= 1'b1;	// First strobe out of reset
			end
		end
	end

	always_comb begin
		cmd = '0;
		cmd.valid = cmd_valid;
		if (cmd_valid) begin
			// Slot 1 is the command address, always a write
			cmd.slot1.cmd.read = 1'b0;
			cmd.slot1.cmd.index = codec_reg_index[entry];
			cmd.slot1.cmd.zero = '0;
			// Slot 2 carries the data to write
			cmd.slot2.data.value = codec_reg_value[entry];
			cmd.slot2.data.zero = '0;
		end
	end

endmodule

// ==== logic/aclink_framer.sv ====
module aclink_framer (
	input  logic                      ac97_bitclk,
	input  logic                      audio_rst_b,
	input  ac97_link_pkg::cmd_slots_t cmd,
	input  ac97_link_pkg::pcm_slots_t pcm,
	output logic                      strobe,
	output logic                      sync,
	output logic                      sdata_out
);
	import ac97_link_pkg::*;

	// Slots 5 to 12 are never used on playback
	localparam int idle_bits = frame_bits - tag_bits - 4 * slot_bits;

	logic [7:0]            bit_cnt;
	logic [tag_bits-1:0]   tag;
	ac97_slot_u            slot1;
	ac97_slot_u            slot2;
	ac97_slot_u            slot3;
	ac97_slot_u            slot4;
	logic [frame_bits-1:0] frame_next;
	logic [frame_bits-1:0] frame_sr;	// Latched frame, shifted out MSB first

	// Counter starts on the last bit so the first edge loads a frame
	always_ff @(posedge ac97_bitclk or negedge audio_rst_b) begin
		if (!audio_rst_b)
			bit_cnt <= 8'(frame_bits - 1);
		else
			bit_cnt <= bit_cnt + 8'd1;
	end

	assign strobe = (bit_cnt == 8'(frame_bits - 1));
	assign sync = (bit_cnt < 8'(tag_bits));	// High across the tag slot

	always_comb begin
		tag = '0;
		tag[15] = cmd.valid || pcm.valid;	// Frame valid
		tag[14] = cmd.valid;
		tag[13] = cmd.valid;
		tag[12] = pcm.valid;
		tag[11] = pcm.valid;

		// Invalid slots go out as zeros
		slot1 = cmd.valid ? cmd.slot1 : '0;
		slot2 = cmd.valid ? cmd.slot2 : '0;
		slot3 = pcm.valid ? pcm.slot3 : '0;
		slot4 = pcm.valid ? pcm.slot4 : '0;

		frame_next = {tag, slot1, slot2, slot3, slot4, {idle_bits{1'b0}}};
	end

	always_ff @(posedge ac97_bitclk or negedge audio_rst_b) begin
		if (!audio_rst_b)
			frame_sr <= '0;
		else if (strobe)
			frame_sr <= frame_next;
		else
			frame_sr <= {frame_sr[frame_bits-2:0], 1'b0};
	end

	assign sdata_out = frame_sr[frame_bits-1];

endmodule

// ==== logic/audio_out.sv ====
module audio_out #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic                         ac97_bitclk,
	input  logic                         audio_rst_b,
	input  logic                         sample_valid,
	output logic                         sample_ready,
	input  audio_stream_pkg::sample_word_t sample_data,
	output logic                         sync,
	output logic                         sdata_out
);
	import audio_stream_pkg::*;
	import ac97_link_pkg::*;

	sample_word_t fifo_word;
	logic         fifo_valid;
	logic         fifo_ready;
	logic         strobe;	// Last bit of each AC-link frame
	cmd_slots_t   cmd;
	pcm_slots_t   pcm;

	sample_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) sample_fifo_i (
		.ac97_bitclk (ac97_bitclk),
		.audio_rst_b (audio_rst_b),
		.in_valid    (sample_valid),
		.in_ready    (sample_ready),
		.in_word     (sample_data),
		.out_valid   (fifo_valid),
		.out_ready   (fifo_ready),
		.out_word    (fifo_word)
	);

	frame_splitter frame_splitter_i (
		.ac97_bitclk (ac97_bitclk),
		.audio_rst_b (audio_rst_b),
		.strobe      (strobe),
		.word_valid  (fifo_valid),
		.word_ready  (fifo_ready),
		.word        (fifo_word),
		.pcm         (pcm)
	);

	codec_config codec_config_i (
		.ac97_bitclk (ac97_bitclk),
		.audio_rst_b (audio_rst_b),
		.strobe      (strobe),
		.cmd         (cmd)
	);

	aclink_framer aclink_framer_i (
		.ac97_bitclk (ac97_bitclk),
		.audio_rst_b (audio_rst_b),
		.cmd         (cmd),
		.pcm         (pcm),
		.strobe      (strobe),
		.sync        (sync),
		.sdata_out   (sdata_out)
	);

endmodule

// ==== tb/tb_clock_gen.sv ====
module tb_clock_gen (
	output logic ac97_bitclk,
	output logic audio_rst_b
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int half_period = 4;	// 8 ns bit clock
	localparam int reset_cycles = 3;

	initial begin
		ac97_bitclk = 1'b0;
		forever #half_period ac97_bitclk = ~ac97_bitclk;
	end

	// Release on a falling edge, away from the active edge
	initial begin
		audio_rst_b = 1'b1;
		#1 audio_rst_b = 1'b0;	// Falling edge ahead of the first clock edge
		repeat (reset_cycles) @(posedge ac97_bitclk);
		@(negedge ac97_bitclk);
		audio_rst_b <= 1'b1;
	end

endmodule

// ==== tb/audio_out_checker.sv ====
module audio_out_checker (
	input  logic                           ac97_bitclk,
	input  logic                           audio_rst_b,
	input  logic                           sample_valid,
	input  logic                           sample_ready,
	input  audio_stream_pkg::sample_word_t sample_data,
	input  logic                           sync,
	input  logic                           sdata_out,
	output int                             pending
);
	timeunit 1ns;
	timeprecision 100ps;
	import audio_stream_pkg::*;

	// Expected codec writes, in the order the codec must see them
	localparam logic [6:0] cfg_index [7] = '{
		7'h02, 7'h0E, 7'h10, 7'h12, 7'h18, 7'h1A, 7'h1C
	};
	localparam logic [15:0] cfg_value [7] = '{
		16'h0000, 16'h8808, 16'h8808, 16'h8808, 16'h0808, 16'h0000, 16'h8000
	};

	logic [31:0]  exp_q [$];	// {left, right} per frame
	int           test_err [6];
	logic [255:0] frame;
	logic         prev_sync = 1'b0;
	logic         in_frame = 1'b0;
	logic         reset_done = 1'b0;
	logic         ready_low_seen = 1'b0;
	logic         gap_after_pcm = 1'b0;
	logic         played_any = 1'b0;
	logic         odd_half = 1'b0;	// Second half of a word still due
	int           cyc = 0;
	int           high_cnt = 0;
	int           frames = 0;
	int           cfg_n = 0;
	int           accepted = 0;
	int           resumes = 0;

	initial begin
		pending = 0;
		foreach (test_err[i])
			test_err[i] = 0;
	end

	task automatic value_fail(input int test, input string name, input logic [31:0] got,
			input logic [31:0] exp);
		test_err[test-1]++;
		$display("[FAIL] test %0d %s: got %h expected %h (frame %0d)", test, name, got, exp,
			frames);
	endtask

	task automatic other_fail(input int test, input string what);
		test_err[test-1]++;
		$display("Error in test %0d at frame %0d: %s", test, frames, what);
	endtask

	task automatic decode_frame(input logic [255:0] f);
		logic [15:0] tag;
		logic [19:0] s1;
		logic [19:0] s2;
		logic [19:0] s3;
		logic [19:0] s4;
		logic [31:0] e;
		tag = f[255:240];
		s1 = f[239:220];
		s2 = f[219:200];
		s3 = f[199:180];
		s4 = f[179:160];

		if (tag[15] != |tag[14:11])
			value_fail(2, "tag bit 15", 32'(tag[15]), 32'(|tag[14:11]));
		if (tag[10:0] != '0)
			value_fail(2, "tag bits 10:0", 32'(tag[10:0]), 32'h0);
		if (tag[14] != tag[13] || tag[12] != tag[11])
			value_fail(2, "tag bits 14:11", 32'(tag[14:11]),
				32'({tag[14], tag[14], tag[12], tag[12]}));
		if (f[159:0] != '0)
			other_fail(2, "slots 5 to 12 are not zero");

		if (tag[14]) begin
			if (cfg_n >= 7) begin
				other_fail(3, "codec write after the table end");
			end else begin
				if (s1 != {1'b0, cfg_index[cfg_n], 12'h000})
					value_fail(3, "slot1", 32'(s1), 32'({1'b0, cfg_index[cfg_n], 12'h000}));
				if (s2 != {cfg_value[cfg_n], 4'h0})
					value_fail(3, "slot2", 32'(s2), 32'({cfg_value[cfg_n], 4'h0}));
			end
			cfg_n++;
		end else if (s1 != '0 || s2 != '0) begin
			value_fail(2, "slot1/slot2 while invalid", 32'(s1 | s2), 32'h0);
		end

		if (tag[12]) begin
			if (exp_q.size() == 0) begin
				other_fail(4, "PCM frame with no accepted sample left to play");
			end else begin
				e = exp_q.pop_front();
				if (s3 != {e[31:16], 4'h0})
					value_fail(4, "slot3", 32'(s3), 32'({e[31:16], 4'h0}));
				if (s4 != {e[15:0], 4'h0})
					value_fail(4, "slot4", 32'(s4), 32'({e[15:0], 4'h0}));
			end
			if (gap_after_pcm)
				resumes++;
			gap_after_pcm = 1'b0;
			odd_half = ~odd_half;
			played_any = 1'b1;
		end else begin
			if (s3 != '0 || s4 != '0)
				value_fail(5, "slot3/slot4 in underrun", 32'(s3 | s4), 32'h0);
			if (odd_half)
				other_fail(5, "underrun between the two halves of a word");
			if (played_any)
				gap_after_pcm = 1'b1;
		end
	endtask

	// Reset values and the input handshake
	always @(posedge ac97_bitclk) begin
		if (!audio_rst_b || !reset_done) begin
			if (sync !== 1'b0)
				value_fail(1, "sync", 32'(sync), 32'h0);
			if (sdata_out !== 1'b0)
				value_fail(1, "sdata_out", 32'(sdata_out), 32'h0);
			if (sample_ready !== 1'b1)
				value_fail(1, "sample_ready", 32'(sample_ready), 32'h1);
			if (audio_rst_b) begin
				reset_done = 1'b1;
				$display("Test 1 reset: %s", (test_err[0] == 0) ? "passed" : "FAILED");
			end
		end
		if (audio_rst_b && sample_valid && sample_ready) begin
			exp_q.push_back({sample_data.left0, sample_data.right0});
			exp_q.push_back({sample_data.left1, sample_data.right1});
			accepted++;
		end
		if (audio_rst_b && !sample_ready)
			ready_low_seen = 1'b1;
	end

	// Serial side, sampled mid-cycle
	always @(negedge ac97_bitclk) begin
		if (audio_rst_b) begin
			if (sync && !prev_sync) begin
				if (in_frame) begin
					frames++;
					if (cyc != 256)
						value_fail(2, "frame length", 32'(cyc), 32'd256);
					if (high_cnt != 16)
						value_fail(2, "sync high cycles", 32'(high_cnt), 32'd16);
					decode_frame(frame);
				end
				in_frame = 1'b1;
				cyc = 1;
				high_cnt = 1;
				frame = {255'b0, sdata_out};
			end else if (in_frame) begin
				cyc++;
				if (sync)
					high_cnt++;
				frame = {frame[254:0], sdata_out};
			end
			prev_sync = sync;
		end
		pending = exp_q.size();
	end

	task automatic report_results(output int total);
		int failed_tests;
		if (!reset_done)
			other_fail(1, "reset was never released");
		if (frames == 0)
			other_fail(2, "no complete frame was seen");
		if (cfg_n != 7)
			other_fail(3, $sformatf("%0d codec writes seen instead of 7", cfg_n));
		if (accepted == 0 || exp_q.size() != 0)
			other_fail(4, $sformatf("%0d halves of accepted words never played",
				exp_q.size()));
		if (resumes == 0)
			other_fail(5, "no playback resumed after an underrun");
		if (!ready_low_seen)
			other_fail(6, "sample_ready never went low during the burst");
		$display("Test 2 frame shape: %s", (test_err[1] == 0) ? "passed" : "FAILED");
		$display("Test 3 codec setup: %s", (test_err[2] == 0) ? "passed" : "FAILED");
		$display("Test 4 sample order: %s", (test_err[3] == 0) ? "passed" : "FAILED");
		$display("Test 5 underrun: %s", (test_err[4] == 0) ? "passed" : "FAILED");
		$display("Test 6 back-pressure: %s", (test_err[5] == 0) ? "passed" : "FAILED");
		total = 0;
		failed_tests = 0;
		foreach (test_err[i]) begin
			total += test_err[i];
			if (test_err[i] != 0)
				failed_tests++;
		end
		$display("Summary: 6 tests, %0d failed, %0d errors, %0d frames, %0d words",
			failed_tests, total, frames, accepted);
	endtask

endmodule

// ==== tb/audio_out_tb.sv ====
module audio_out_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import audio_stream_pkg::*;

	localparam int n_words = 40;
	localparam int frame_cycles = 256;

	logic         clk;
	logic         rst_b;
	logic         sample_valid;
	logic         sample_ready;
	logic         sync;
	logic         sdata_out;
	sample_word_t sample_data;
	sample_word_t word_tab [n_words];
	int           gap_tab [n_words];	// Idle cycles before each word
	int           cycles;
	int           cycle_limit;
	int           pending;
	int           errors;

	tb_clock_gen clock_gen_i (
		.ac97_bitclk (clk),
		.audio_rst_b (rst_b)
	);

	audio_out #(
		.FIFO_DEPTH (16)
	) audio_out_i (
		.ac97_bitclk  (clk),
		.audio_rst_b  (rst_b),
		.sample_valid (sample_valid),
		.sample_ready (sample_ready),
		.sample_data  (sample_data),
		.sync         (sync),
		.sdata_out    (sdata_out)
	);

	audio_out_checker checker_i (
		.ac97_bitclk  (clk),
		.audio_rst_b  (rst_b),
		.sample_valid (sample_valid),
		.sample_ready (sample_ready),
		.sample_data  (sample_data),
		.sync         (sync),
		.sdata_out    (sdata_out),
		.pending      (pending)
	);

	task automatic fill_table();
		for (int i = 0; i < n_words; i++) begin
			word_tab[i] = {$urandom, $urandom};
			if (i < 10)
				gap_tab[i] = $urandom % 700;	// Sparse, underruns likely
			else if (i < 34)
				gap_tab[i] = 0;	// Burst to fill the FIFO
			else if (i == 34)
				gap_tab[i] = 10000;	// Long enough to drain everything
			else
				gap_tab[i] = $urandom % 300;
		end
	endtask

	initial begin
		void'($urandom(26951));
		sample_valid = 1'b0;
		sample_data = '0;
		cycles = 0;
		fill_table();
		cycle_limit = (n_words + 10) * 2 * frame_cycles;
		foreach (gap_tab[i])
			cycle_limit += gap_tab[i];

		wait (rst_b === 1'b1);
		@(negedge clk);
		for (int i = 0; i < n_words; i++) begin
			if (gap_tab[i] > 0) begin
				sample_valid = 1'b0;
				repeat (gap_tab[i]) @(negedge clk);
			end
			sample_valid = 1'b1;
			sample_data = word_tab[i];
			while (!sample_ready)
				@(negedge clk);
			@(negedge clk);	// Transfer took place on the rising edge
		end
		sample_valid = 1'b0;

		repeat (2) @(negedge clk);
		while (pending != 0)
			@(negedge clk);
		repeat (3 * frame_cycles) @(negedge clk);	// Trailing underrun frames

		checker_i.report_results(errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Timeout: run did not finish within %0d cycles", cycle_limit);
			$display("Test failed");
			$finish;
		end
	end

endmodule

// ==== all.f ====
logic/audio_stream_pkg.sv
logic/ac97_link_pkg.sv
logic/sample_fifo.sv
logic/frame_splitter.sv
logic/codec_config.sv
logic/aclink_framer.sv
logic/audio_out.sv
tb/tb_clock_gen.sv
tb/audio_out_checker.sv
tb/audio_out_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the audio_out testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module audio_out_tb \
	-f all.f -Mdir obj_dir -o audio_out_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/audio_out_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -q "^Test completed successfully$"; then
	exit 0
fi
exit 1
